// ==== Bender.yml ====
package:
  name: alu_ft

sources:
  - verilog/alu_ft_pkg.sv
  - verilog/alu_replica.sv
  - verilog/replica_select.sv
  - verilog/tmr_voter.sv
  - verilog/fault_counter.sv
  - verilog/alu_ft_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_alu_ft_top.sv

// ==== alu_ft_top.f ====
+incdir+test
verilog/alu_ft_pkg.sv
verilog/alu_replica.sv
verilog/replica_select.sv
verilog/tmr_voter.sv
verilog/fault_counter.sv
verilog/alu_ft_top.sv
test/tb_alu_ft_top.sv

// ==== test/tb_alu_ft_vectors.svh ====
// stimulus table of the fault tolerant alu testbench
// Fixed rows for every operator, single and double faults, replica swap,
// only-two mode, bypass and a held replica, plus the row for error counting.

`ifndef TB_ALU_FT_VECTORS_SVH
`define TB_ALU_FT_VECTORS_SVH

// columns: op, operand a, operand b, fault mask, clock enable, sel_mux_ex, only two,
//          sel_only_two, bypass, expected result, expected {comparison, detected, corrected}
// fault mask bit k flips operand a of replica k with 32'h10 << k

localparam int unsigned NUM_FIXED = 25;

localparam vec_t FIXED_ROWS [NUM_FIXED] = '{
	{ALU_ADD,  32'hf0000013, 32'h4, 4'h0, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'hf0000017, 3'b000},
	{ALU_SUB,  32'hf0000013, 32'h4, 4'h0, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'hf000000f, 3'b000},
	{ALU_AND,  32'hf0000013, 32'h4, 4'h0, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'h00000000, 3'b000},
	{ALU_OR,   32'hf0000013, 32'h4, 4'h0, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'hf0000017, 3'b000},
	{ALU_XOR,  32'hf0000013, 32'h4, 4'h0, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'hf0000017, 3'b000},
	{ALU_SLL,  32'hf0000013, 32'h4, 4'h0, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'h00000130, 3'b000},
	{ALU_SRL,  32'hf0000013, 32'h4, 4'h0, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'h0f000001, 3'b000},
	{ALU_SRA,  32'hf0000013, 32'h4, 4'h0, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'hff000001, 3'b000},
	{ALU_SLT,  32'hf0000013, 32'h4, 4'h0, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'h00000001, 3'b100},
	{ALU_SLTU, 32'hf0000013, 32'h4, 4'h0, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'h00000000, 3'b000},
	{ALU_EQ,   32'hf0000013, 32'h4, 4'h0, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'h00000000, 3'b000},
	{ALU_EQ, 32'h12345678, 32'h12345678, 4'h0, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'h1, 3'b100},
	// single faults, selected and deselected replica
	{ALU_ADD, 32'h100, 32'h1, 4'h2, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE,  32'h101, 3'b011},
	{ALU_ADD, 32'h100, 32'h1, 4'h8, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE,  32'h101, 3'b000},
	// replica 3 swapped into slot 2
	{ALU_ADD, 32'h100, 32'h1, 4'h2, 4'hf, 3'b010, 1'b0, 2'b00, BYP_VOTE,  32'h101, 3'b000},
	{ALU_ADD, 32'h100, 32'h1, 4'h8, 4'hf, 3'b010, 1'b0, 2'b00, BYP_VOTE,  32'h101, 3'b011},
	// only-two mode
	{ALU_ADD, 32'h100, 32'h1, 4'h2, 4'hf, 3'b000, 1'b1, 2'b00, BYP_VOTE,  32'h101, 3'b010},
	{ALU_ADD, 32'h100, 32'h1, 4'h1, 4'hf, 3'b000, 1'b1, 2'b00, BYP_VOTE,  32'h111, 3'b010},
	{ALU_ADD, 32'h100, 32'h1, 4'h1, 4'hf, 3'b000, 1'b1, 2'b01, BYP_VOTE,  32'h101, 3'b000},
	// bypass of a faulty slot
	{ALU_ADD, 32'h100, 32'h1, 4'h2, 4'hf, 3'b000, 1'b0, 2'b00, BYP_SLOT2, 32'h121, 3'b011},
	{ALU_ADD, 32'h100, 32'h1, 4'h1, 4'hf, 3'b000, 1'b0, 2'b00, BYP_SLOT1, 32'h111, 3'b011},
	{ALU_ADD, 32'h100, 32'h1, 4'h4, 4'hf, 3'b000, 1'b0, 2'b00, BYP_SLOT3, 32'h141, 3'b011},
	// two faults, three different slot values
	{ALU_ADD, 32'h100, 32'h1, 4'h3, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE,  32'h111, 3'b010},
	// replica 0 parked and swapped out while its request changes
	{ALU_ADD, 32'h100, 32'h1, 4'h0, 4'he, 3'b001, 1'b0, 2'b00, BYP_VOTE,  32'h101, 3'b000},
	// back in slot 1, still holding the outcome of the two fault row
	{ALU_ADD, 32'h100, 32'h1, 4'h0, 4'he, 3'b000, 1'b0, 2'b00, BYP_VOTE,  32'h101, 3'b011}
};

// repeated until replica 1 reaches the fault threshold
localparam vec_t COUNT_ROW =
	{ALU_ADD, 32'h100, 32'h1, 4'h2, 4'hf, 3'b000, 1'b0, 2'b00, BYP_VOTE, 32'h101, 3'b011};

`endif

// ==== test/tb_alu_ft_top.sv ====
// testbench of the fault tolerant alu stage
// Applies a table of fixed and random requests to the DUT, compares the
// voted or bypassed outcome with a reference model and drives one replica
// into a permanent fault to check the error counters and their read port.

`timescale 1ns/1ps
`default_nettype none

module tb_alu_ft_top;

	import alu_ft_pkg::*;

	localparam int unsigned THRESH     = 4;
	localparam int unsigned CLK_PERIOD = 8;
	localparam int unsigned NUM_RAND   = 24;

	typedef struct packed {
		alu_op_e     op;
		logic [31:0] a;
		logic [31:0] b;
		logic [3:0]  fault;	// per replica operand a corruption
		logic [3:0]  clock_en;
		logic [2:0]  sel_ex;
		logic        only_two;
		logic [1:0]  sel_two;
		bypass_e     byp;
		logic [31:0] exp_res;
		logic        exp_cmp;
		logic        exp_det;
		logic        exp_cor;
	} vec_t;

	`include "tb_alu_ft_vectors.svh"

	localparam int unsigned NUM_ROWS = NUM_FIXED + NUM_RAND;

	logic                        clk;
	logic                        rst_n_i;
	alu_req_t [NUM_REPLICAS-1:0] req;
	logic [NUM_REPLICAS-1:0]     clock_en;
	logic [2:0]                  sel_mux_ex;
	logic                        only_two;
	logic [1:0]                  sel_only_two;
	bypass_e                     sel_bypass;
	logic [11:0]                 cnt_addr;
	logic                        cnt_re;
	logic [31:0]                 result;
	logic                        comparison;
	logic                        valid;
	logic                        err_det;
	logic                        err_cor;
	logic [NUM_REPLICAS-1:0]     perm_faulty;
	logic [31:0]                 cnt_rdata;

	vec_t        rows [NUM_ROWS];
	integer      seed;
	int unsigned n_pass;
	int unsigned n_fail;
	logic        test_bad;

	alu_ft_top #(
		.DATA_WIDTH    ( 32     ),
		.ERR_THRESHOLD ( THRESH )
	) i_alu_ft_top (
		.clk                ( clk          ),
		.rst_n_i            ( rst_n_i      ),
		.req_i              ( req          ),
		.clock_en_i         ( clock_en     ),
		.sel_mux_ex_i       ( sel_mux_ex   ),
		.only_two_i         ( only_two     ),
		.sel_only_two_i     ( sel_only_two ),
		.sel_bypass_i       ( sel_bypass   ),
		.cnt_addr_i         ( cnt_addr     ),
		.cnt_re_i           ( cnt_re       ),
		.result_o           ( result       ),
		.comparison_o       ( comparison   ),
		.valid_o            ( valid        ),
		.err_detected_o     ( err_det      ),
		.err_corrected_o    ( err_cor      ),
		.permanent_faulty_o ( perm_faulty  ),
		.cnt_rdata_o        ( cnt_rdata    )
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// run length is the table plus the counter sequence and some margin
	initial begin
		#((NUM_ROWS + THRESH + 20) * CLK_PERIOD);
		$display("timeout, the test sequence did not complete in time");
		$display("CHECKS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model

	function automatic logic [31:0] faulty_a(input vec_t v, input int k);
		return v.fault[k] ? v.a ^ (32'h10 << k) : v.a;
	endfunction

	function automatic alu_out_t model_replica(input vec_t v, input int k);
		logic [31:0] a;
		alu_out_t    o;
		a       = faulty_a(v, k);
		o       = '0;
		o.valid = 1'b1;
		case (v.op)
			ALU_ADD:  o.result = a + v.b;
			ALU_SUB:  o.result = a - v.b;
			ALU_AND:  o.result = a & v.b;
			ALU_OR:   o.result = a | v.b;
			ALU_XOR:  o.result = a ^ v.b;
			ALU_SLL:  o.result = a << v.b[4:0];
			ALU_SRL:  o.result = a >> v.b[4:0];
			ALU_SRA:  o.result = $signed(a) >>> v.b[4:0];
			ALU_SLT:  o.comparison = $signed(a) < $signed(v.b);
			ALU_SLTU: o.comparison = a < v.b;
			ALU_EQ:   o.comparison = a == v.b;
			default:  o.result = '0;
		endcase
		if (v.op inside {ALU_SLT, ALU_SLTU, ALU_EQ}) begin
			o.result = {31'b0, o.comparison};	// flag also lands on the result
		end
		return o;
	endfunction

	// fills in the expected columns from selection, vote and bypass rules
	task automatic expect_row(inout vec_t v);
		alu_out_t rep [NUM_REPLICAS];
		alu_out_t s [NUM_SLOTS];
		alu_out_t out;
		for (int k = 0; k < NUM_REPLICAS; k++) begin
			rep[k] = model_replica(v, k);
		end
		for (int k = 0; k < NUM_SLOTS; k++) begin
			s[k] = v.sel_ex[k] ? rep[3] : rep[k];
		end
		if (v.only_two) begin
			for (int k = 0; k < 2; k++) begin
				if (v.sel_two[k]) begin
					s[k] = s[2];
				end
			end
			out       = s[0];
			v.exp_det = s[0] != s[1];
			v.exp_cor = 1'b0;
		end else begin
			out       = (s[0] != s[1] && s[0] != s[2] && s[1] == s[2]) ? s[1] : s[0];
			v.exp_det = !(s[0] == s[1] && s[1] == s[2]);
			v.exp_cor = v.exp_det && (s[0] == s[1] || s[0] == s[2] || s[1] == s[2]);
		end
		if (v.byp != BYP_VOTE) begin
			out = s[v.byp - 1];
		end
		v.exp_res = out.result;
		v.exp_cmp = out.comparison;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// drive and check

	task automatic drive_req(input vec_t v);
		alu_req_t [NUM_REPLICAS-1:0] r;
		for (int k = 0; k < NUM_REPLICAS; k++) begin
			r[k].enable    = 1'b1;
			r[k].operator  = v.op;
			r[k].operand_a = faulty_a(v, k);
			r[k].operand_b = v.b;
		end
		req      <= r;
		clock_en <= v.clock_en;
	endtask

	task automatic drive_sel(input vec_t v);
		sel_mux_ex   <= v.sel_ex;
		only_two     <= v.only_two;
		sel_only_two <= v.sel_two;
		sel_bypass   <= v.byp;
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("error %s: got %h, expected %h", name, got, exp);
			test_bad = 1'b1;
		end
	endtask

	task automatic report_test(input string what);
		if (test_bad) begin
			n_fail++;
		end else begin
			n_pass++;
		end
		$display("%s %s", what, test_bad ? "failed" : "ok");
		test_bad = 1'b0;
	endtask

	task automatic check_row(input int i);
		check_val("result_o", result, rows[i].exp_res);
		check_val("comparison_o", 32'(comparison), 32'(rows[i].exp_cmp));
		check_val("valid_o", 32'(valid), 32'h1);
		check_val("err_detected_o", 32'(err_det), 32'(rows[i].exp_det));
		check_val("err_corrected_o", 32'(err_cor), 32'(rows[i].exp_cor));
		report_test($sformatf("row %0d", i));
	endtask

	initial begin
		rst_n_i      = 1'b0;
		req          = '0;
		clock_en     = '0;
		sel_mux_ex   = '0;
		only_two     = 1'b0;
		sel_only_two = '0;
		sel_bypass   = BYP_VOTE;
		cnt_addr     = '0;
		cnt_re       = 1'b0;
		seed         = 32'hb65a93bc;
		n_pass       = 0;
		n_fail       = 0;
		test_bad     = 1'b0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			if (i < NUM_FIXED) begin
				rows[i] = FIXED_ROWS[i];
			end else begin
				rows[i]          = '0;
				rows[i].op       = alu_op_e'(4'($unsigned($random(seed)) % 11));
				rows[i].a        = $random(seed);
				rows[i].b        = $random(seed);
				rows[i].fault    = 4'($random(seed));
				rows[i].clock_en = 4'hf;
				rows[i].sel_ex   = 3'($random(seed));
				rows[i].only_two = 1'($random(seed));
				rows[i].sel_two  = 2'($random(seed));
				rows[i].byp      = bypass_e'(2'($random(seed)));
				expect_row(rows[i]);
			end
		end
		repeat (3) @(posedge clk);
		rst_n_i <= 1'b1;

		// selects follow their request by one cycle, matching the output register
		for (int i = 0; i <= NUM_ROWS; i++) begin
			if (i < NUM_ROWS) begin
				drive_req(rows[i]);
			end
			if (i > 0) begin
				drive_sel(rows[i-1]);
				@(negedge clk);
				check_row(i - 1);
			end
			@(posedge clk);
		end

		// error counting from a clean reset
		rst_n_i <= 1'b0;
		req     <= '0;
		drive_sel(COUNT_ROW);
		repeat (2) @(posedge clk);
		rst_n_i <= 1'b1;
		for (int i = 0; i < THRESH; i++) begin
			drive_req(COUNT_ROW);
			@(posedge clk);
		end
		req <= '0;
		@(posedge clk);	// last count lands on this edge
		for (int n = 0; n <= NUM_REPLICAS + 1; n++) begin
			cnt_re   <= (n <= NUM_REPLICAS);
			// the last read is past the map, its low offset bits name replica 1
			cnt_addr <= CNT_ADDR_BASE + 12'((n < NUM_REPLICAS) ? n : n + 1);
			if (n > 0) begin
				@(negedge clk);
				check_val("cnt_rdata_o", cnt_rdata, (n == 2) ? THRESH : 0);
				report_test($sformatf("counter read %0d", n - 1));
			end
			@(posedge clk);
		end
		check_val("permanent_faulty_o", 32'(perm_faulty), 32'h2);
		report_test("permanent fault flag");

		$display("tests passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/alu_ft_pkg.sv ====
// fault tolerant alu package
// Holds the shared definitions of the replicated ALU stage: the operator
// encoding, the request and outcome structs, the replica and slot counts,
// the slot map type, the bypass encoding and the error counter address map.

`default_nettype none

package alu_ft_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes

	localparam int unsigned NUM_REPLICAS  = 4;	// physical alu copies
	localparam int unsigned NUM_SLOTS     = 3;	// voter inputs
	localparam int unsigned DATA_WIDTH    = 32;
	localparam int unsigned REPLICA_IDX_W = $clog2(NUM_REPLICAS);

	////////////////////////////////////////////////////////////////////////////
	// operator encoding

	typedef enum logic [3:0] {
		ALU_ADD  = 4'h0,
		ALU_SUB  = 4'h1,
		ALU_AND  = 4'h2,
		ALU_OR   = 4'h3,
		ALU_XOR  = 4'h4,
		ALU_SLL  = 4'h5,
		ALU_SRL  = 4'h6,
		ALU_SRA  = 4'h7,
		ALU_SLT  = 4'h8,	// signed less than
		ALU_SLTU = 4'h9,
		ALU_EQ   = 4'hA
	} alu_op_e;

	// one request per replica, each copy gets its own operands
	typedef struct packed {
		logic                  enable;
		alu_op_e               operator;
		logic [DATA_WIDTH-1:0] operand_a;
		logic [DATA_WIDTH-1:0] operand_b;
	} alu_req_t;

	// registered outcome of one replica
	typedef struct packed {
		logic                  valid;
		logic [DATA_WIDTH-1:0] result;
		logic                  comparison;	// only set by slt, sltu, eq
	} alu_out_t;

	// physical replica feeding each voter slot
	typedef logic [NUM_SLOTS-1:0][REPLICA_IDX_W-1:0] slot_map_t;

	// output source, the vote or one slot taken directly
	typedef enum logic [1:0] {
		BYP_VOTE  = 2'd0,
		BYP_SLOT1 = 2'd1,
		BYP_SLOT2 = 2'd2,
		BYP_SLOT3 = 2'd3
	} bypass_e;

	// counter of replica n sits at CNT_ADDR_BASE + n
	localparam logic [11:0] CNT_ADDR_BASE = 12'hB10;

endpackage

`default_nettype wire

// ==== verilog/alu_ft_top.sv ====
// fault tolerant alu stage
// Four ALU replicas feed a selection network that picks three of them for a
// majority voter. The output is either the vote or a single slot through
// the bypass mux. Voter error flags are attributed to physical replicas
// and counted to detect permanently faulty units.

`timescale 1ns/1ps
`default_nettype none

module alu_ft_top #(
	parameter int unsigned DATA_WIDTH    = alu_ft_pkg::DATA_WIDTH,
	parameter int unsigned ERR_THRESHOLD = 4
) (
	input  logic                                                clk,
	input  logic                                                rst_n_i,
	input  alu_ft_pkg::alu_req_t [alu_ft_pkg::NUM_REPLICAS-1:0] req_i,
	input  logic [alu_ft_pkg::NUM_REPLICAS-1:0]                 clock_en_i,
	input  logic [2:0]                                          sel_mux_ex_i,
	input  logic                                                only_two_i,
	input  logic [1:0]                                          sel_only_two_i,
	input  alu_ft_pkg::bypass_e                                 sel_bypass_i,
	input  logic [11:0]                                         cnt_addr_i,
	input  logic                                                cnt_re_i,
	output logic [DATA_WIDTH-1:0]                               result_o,
	output logic                                                comparison_o,
	output logic                                                valid_o,
	output logic                                                err_detected_o,
	output logic                                                err_corrected_o,
	output logic [alu_ft_pkg::NUM_REPLICAS-1:0]                 permanent_faulty_o,
	output logic [31:0]                                         cnt_rdata_o
);

	import alu_ft_pkg::*;

	alu_out_t [NUM_REPLICAS-1:0] replica_out;
	alu_out_t [NUM_SLOTS-1:0]    slot_out;
	slot_map_t                   slot_map;
	alu_out_t                    voted;
	logic [NUM_SLOTS-1:0]        slot_err;
	alu_out_t                    stage_out;

	////////////////////////////////////////////////////////////////////////////
	// replicas

	for (genvar r = 0; r < NUM_REPLICAS; r++) begin : gen_replica
		alu_replica #(
			.DATA_WIDTH ( DATA_WIDTH )
		) i_alu_replica (
			.clk        ( clk            ),
			.rst_n_i    ( rst_n_i        ),
			.clock_en_i ( clock_en_i[r]  ),
			.req_i      ( req_i[r]       ),
			.out_o      ( replica_out[r] )
		);
	end

	replica_select i_replica_select (
		.replica_out_i  ( replica_out    ),
		.sel_mux_ex_i   ( sel_mux_ex_i   ),
		.only_two_i     ( only_two_i     ),
		.sel_only_two_i ( sel_only_two_i ),
		.slot_o         ( slot_out       ),
		.slot_map_o     ( slot_map       )
	);

	tmr_voter i_tmr_voter (
		.slot_i          ( slot_out        ),
		.only_two_i      ( only_two_i      ),
		.voted_o         ( voted           ),
		.slot_err_o      ( slot_err        ),
		.err_detected_o  ( err_detected_o  ),	// reported even under bypass
		.err_corrected_o ( err_corrected_o )
	);

	fault_counter #(
		.ERR_THRESHOLD ( ERR_THRESHOLD )
	) i_fault_counter (
		.clk                ( clk                ),
		.rst_n_i            ( rst_n_i            ),
		.vote_valid_i       ( voted.valid        ),
		.slot_err_i         ( slot_err           ),
		.slot_map_i         ( slot_map           ),
		.cnt_addr_i         ( cnt_addr_i         ),
		.cnt_re_i           ( cnt_re_i           ),
		.cnt_rdata_o        ( cnt_rdata_o        ),
		.permanent_faulty_o ( permanent_faulty_o )
	);

	////////////////////////////////////////////////////////////////////////////
	// bypass, used when too few healthy replicas remain for a vote

	always_comb begin
		case (sel_bypass_i)
			BYP_SLOT1: stage_out = slot_out[0];
			BYP_SLOT2: stage_out = slot_out[1];
			BYP_SLOT3: stage_out = slot_out[2];
			default:   stage_out = voted;
		endcase
	end

	assign result_o     = stage_out.result;
	assign comparison_o = stage_out.comparison;
	assign valid_o      = stage_out.valid;

endmodule

`default_nettype wire

// ==== verilog/alu_replica.sv ====
// alu replica
// One copy of the integer ALU. The operation is computed combinationally
// and captured with its valid bit in an output register, which holds its
// contents while the replica's clock enable is low.

`timescale 1ns/1ps
`default_nettype none

module alu_replica #(
	parameter int unsigned DATA_WIDTH = alu_ft_pkg::DATA_WIDTH
) (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 clock_en_i,	// low parks the unit
	input  alu_ft_pkg::alu_req_t req_i,
	output alu_ft_pkg::alu_out_t out_o
);

	import alu_ft_pkg::*;

	localparam int unsigned SHAMT_W = $clog2(DATA_WIDTH);

	logic [DATA_WIDTH-1:0] op_a;
	logic [DATA_WIDTH-1:0] op_b;
	logic [SHAMT_W-1:0]    shamt;
	logic [DATA_WIDTH-1:0] result_d;
	logic                  cmp_d;
	alu_out_t              out_q;

	assign op_a  = req_i.operand_a;
	assign op_b  = req_i.operand_b;
	assign shamt = op_b[SHAMT_W-1:0];	// only the low bits shift

	////////////////////////////////////////////////////////////////////////////
	// operation decode

	always_comb begin
		result_d = '0;
		cmp_d    = 1'b0;
		case (req_i.operator)
			ALU_ADD:  result_d = op_a + op_b;
			ALU_SUB:  result_d = op_a - op_b;
			ALU_AND:  result_d = op_a & op_b;
			ALU_OR:   result_d = op_a | op_b;
			ALU_XOR:  result_d = op_a ^ op_b;
			ALU_SLL:  result_d = op_a << shamt;
			ALU_SRL:  result_d = op_a >> shamt;
			ALU_SRA:  result_d = $signed(op_a) >>> shamt;
			ALU_SLT:  cmp_d = $signed(op_a) < $signed(op_b);
			ALU_SLTU: cmp_d = op_a < op_b;
			ALU_EQ:   cmp_d = op_a == op_b;
			default:  result_d = '0;
		endcase
		// comparisons also return their flag zero extended on the result
		if (req_i.operator inside {ALU_SLT, ALU_SLTU, ALU_EQ}) begin
			result_d = {{(DATA_WIDTH-1){1'b0}}, cmp_d};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// gated output register

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			out_q <= '0;
		end else if (clock_en_i) begin
			if (req_i.enable) begin
				out_q.valid      <= 1'b1;
				out_q.result     <= result_d;
				out_q.comparison <= cmp_d;
			end else begin
				out_q <= '0;	// idle replicas agree on an all zero outcome
			end
		end
	end

	assign out_o = out_q;

	// a request must carry one of the eleven defined operators
	a_op_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		req_i.enable |-> req_i.operator inside {[ALU_ADD:ALU_EQ]});

endmodule

`default_nettype wire

// ==== verilog/fault_counter.sv ====
// replica error counters
// Maps the voter's per-slot error flags back to physical replicas, keeps a
// saturating error count per replica and raises a sticky permanent fault
// flag once a count reaches the threshold. The counts are readable through
// a registered CSR style port, unmapped addresses read zero.

`timescale 1ns/1ps
`default_nettype none

module fault_counter #(
	parameter int unsigned ERR_THRESHOLD = 4,
	parameter int unsigned CNT_WIDTH     = 16
) (
	input  logic                                 clk,
	input  logic                                 rst_n_i,
	input  logic                                 vote_valid_i,
	input  logic [alu_ft_pkg::NUM_SLOTS-1:0]     slot_err_i,
	input  alu_ft_pkg::slot_map_t                slot_map_i,
	input  logic [11:0]                          cnt_addr_i,
	input  logic                                 cnt_re_i,	// read strobe
	output logic [31:0]                          cnt_rdata_o,
	output logic [alu_ft_pkg::NUM_REPLICAS-1:0]  permanent_faulty_o
);

	import alu_ft_pkg::*;

	logic [NUM_REPLICAS-1:0]                replica_err;
	logic [NUM_REPLICAS-1:0][CNT_WIDTH-1:0] cnt_q;
	logic [NUM_REPLICAS-1:0][CNT_WIDTH-1:0] cnt_d;
	logic [NUM_REPLICAS-1:0]                perm_q;
	logic [11:0]                            addr_off;
	logic                                   addr_hit;
	logic [31:0]                            rdata_q;

	////////////////////////////////////////////////////////////////////////////
	// slot to replica attribution

	always_comb begin
		replica_err = '0;
		if (vote_valid_i) begin
			for (int k = 0; k < NUM_SLOTS; k++) begin
				if (slot_err_i[k]) begin
					replica_err[slot_map_i[k]] = 1'b1;
				end
			end
		end
	end

	// next count, stuck at all ones
	always_comb begin
		for (int n = 0; n < NUM_REPLICAS; n++) begin
			cnt_d[n] = cnt_q[n];
			if (replica_err[n] && (cnt_q[n] != '1)) begin
				cnt_d[n] = cnt_q[n] + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cnt_q  <= '0;
			perm_q <= '0;
		end else begin
			cnt_q <= cnt_d;
			for (int n = 0; n < NUM_REPLICAS; n++) begin
				if (cnt_d[n] >= ERR_THRESHOLD) begin
					perm_q[n] <= 1'b1;	// set together with the count
				end
			end
		end
	end

	assign permanent_faulty_o = perm_q;

	////////////////////////////////////////////////////////////////////////////
	// read port

	assign addr_off = cnt_addr_i - CNT_ADDR_BASE;
	assign addr_hit = (cnt_addr_i >= CNT_ADDR_BASE) && (addr_off < 12'(NUM_REPLICAS));

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rdata_q <= '0;
		end else if (cnt_re_i) begin
			rdata_q <= addr_hit ? 32'(cnt_q[addr_off[REPLICA_IDX_W-1:0]]) : '0;
		end
	end

	assign cnt_rdata_o = rdata_q;

	// only reset clears a permanent fault
	a_perm_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
		(~permanent_faulty_o & $past(permanent_faulty_o)) == '0);

endmodule

`default_nettype wire

// ==== verilog/replica_select.sv ====
// replica selection network
// Picks three of the four replica outcomes for the voter slots. In only-two
// mode slots 1 and 2 can be redirected to the source of slot 3. Reports the
// physical replica behind every slot so errors land on the right counter.

`timescale 1ns/1ps
`default_nettype none

module replica_select (
	input  alu_ft_pkg::alu_out_t [alu_ft_pkg::NUM_REPLICAS-1:0] replica_out_i,
	input  logic [2:0]                                          sel_mux_ex_i,
	input  logic                                                only_two_i,
	input  logic [1:0]                                          sel_only_two_i,
	output alu_ft_pkg::alu_out_t [alu_ft_pkg::NUM_SLOTS-1:0]    slot_o,
	output alu_ft_pkg::slot_map_t                               slot_map_o
);

	import alu_ft_pkg::*;

	alu_out_t [NUM_SLOTS-1:0] first_slot;
	slot_map_t                first_map;

	// first level, slot k takes replica k or the spare replica 3
	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			first_map[k]  = sel_mux_ex_i[k] ? REPLICA_IDX_W'(NUM_REPLICAS - 1)
			                                : REPLICA_IDX_W'(k);
			first_slot[k] = replica_out_i[first_map[k]];
		end
	end

	// second level, only active with two healthy units left
	always_comb begin
		slot_o     = first_slot;
		slot_map_o = first_map;
		if (only_two_i) begin
			for (int k = 0; k < 2; k++) begin
				if (sel_only_two_i[k]) begin
					slot_o[k]     = first_slot[NUM_SLOTS-1];
					slot_map_o[k] = first_map[NUM_SLOTS-1];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tmr_voter.sv ====
// majority voter
// Votes over three slot outcomes compared as whole structs. A single
// dissenter is outvoted and corrected, three different values are only
// detected. In only-two mode slots 1 and 2 are compared and slot 1 wins.

`timescale 1ns/1ps
`default_nettype none

module tmr_voter (
	input  alu_ft_pkg::alu_out_t [alu_ft_pkg::NUM_SLOTS-1:0] slot_i,
	input  logic                                             only_two_i,
	output alu_ft_pkg::alu_out_t                             voted_o,
	output logic [alu_ft_pkg::NUM_SLOTS-1:0]                 slot_err_o,	// dissenting slots
	output logic                                             err_detected_o,
	output logic                                             err_corrected_o
);

	import alu_ft_pkg::*;

	logic eq_12;
	logic eq_13;
	logic eq_23;

	assign eq_12 = slot_i[0] == slot_i[1];
	assign eq_13 = slot_i[0] == slot_i[2];
	assign eq_23 = slot_i[1] == slot_i[2];

	always_comb begin
		voted_o         = slot_i[0];
		slot_err_o      = '0;
		err_detected_o  = 1'b0;
		err_corrected_o = 1'b0;
		if (only_two_i) begin
			// two units can only tell that they disagree
			if (!eq_12) begin
				err_detected_o = 1'b1;
				slot_err_o     = 3'b011;
			end
		end else if (eq_12 && eq_13) begin
			voted_o = slot_i[0];	// unanimous
		end else if (eq_12) begin
			err_detected_o  = 1'b1;
			err_corrected_o = 1'b1;
			slot_err_o      = 3'b100;
		end else if (eq_13) begin
			err_detected_o  = 1'b1;
			err_corrected_o = 1'b1;
			slot_err_o      = 3'b010;
		end else if (eq_23) begin
			voted_o         = slot_i[1];	// slot 1 is the odd one out
			err_detected_o  = 1'b1;
			err_corrected_o = 1'b1;
			slot_err_o      = 3'b001;
		end else begin
			err_detected_o = 1'b1;
			slot_err_o     = '1;
		end
	end

	// a correction blames exactly one slot and needs the full three way vote
	a_corr_single: assert final (!err_corrected_o
		|| (err_detected_o && !only_two_i && $onehot(slot_err_o)));

endmodule

`default_nettype wire
